//--- Makefile
# Verilator build and run of the regrouper testbench
# override any variable on the command line, e.g. make test LOG=run.log

VERILATOR ?= verilator
TOP       ?= tb_regroup
FLIST     ?= tb.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
SIM_ARGS  ?= +verilator+error+limit+100

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the simulation, check the log"
	@echo "  clean  remove the build directory and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- avl_regroup_out.sv
// output stage, reads one or two words per cycle so every sop opens a beat
// and decodes the end code into avalon-st eop, empty and error
`timescale 1ns/1ns
`default_nettype none

module avl_regroup_out #(
   parameter int WORD_WIDTH = 64
) (
   input  logic                                          clk,
   input  logic                                          arst,
   word_rd_if.consumer                                   rd,
   output logic [ilk_word_pkg::NUM_SLOTS*WORD_WIDTH-1:0] avl_dout,
   output logic                                          avl_sop,
   output logic                                          avl_eop,
   output logic [avl_st_pkg::EMPTY_W-1:0]                avl_empty,
   output logic                                          avl_valid,
   output logic                                          avl_error
);

   localparam int EW = avl_st_pkg::EMPTY_W;
   localparam logic [EW-1:0] WORD_BYTES = EW'(avl_st_pkg::BYTES_PER_WORD);

   ilk_word_pkg::entry_t    first_ctl;
   ilk_word_pkg::eop_code_t beat_code;
   logic [1:0]              take_n;
   logic                    beat_go, one_word;
   logic                    eop_n, err_n;
   logic [EW-1:0]           end_bytes, empty_n;

   assign first_ctl = rd.head_ctl[1];

   //////////////////////////////////////////////////////////////////////
   // read schedule
   //////////////////////////////////////////////////////////////////////

   // a packet end closes the beat early, so the next one starts on sop
   always_comb begin
      if (rd.held == '0) begin
         take_n = 2'd0;
      end else if (ilk_word_pkg::ends_packet(first_ctl.eop)) begin
         take_n = 2'd1;
      end else if (rd.held >= 2) begin
         take_n = 2'd2;
      end else begin
         take_n = 2'd0;
      end
   end

   assign rd.take  = take_n;
   assign beat_go  = take_n != 2'd0;
   assign one_word = take_n == 2'd1;

   // end code comes from the last word of the beat
   assign beat_code = one_word ? rd.head_ctl[1].eop : rd.head_ctl[0].eop;

   //////////////////////////////////////////////////////////////////////
   // end code decode
   //////////////////////////////////////////////////////////////////////

   always_comb begin
      // count 0 is a full word
      end_bytes = (beat_code.f.cnt == 3'd0) ? WORD_BYTES : EW'(beat_code.f.cnt);
      eop_n     = ilk_word_pkg::ends_packet(beat_code);
      err_n     = beat_code.raw == ilk_word_pkg::ERR_CODE;
      // error marker has no end flag, reads as empty 0
      if (beat_code.f.endf) begin
         empty_n = WORD_BYTES - end_bytes;
      end else begin
         empty_n = '0;
      end
      // lower word of a single word beat is all empty
      if (one_word && !err_n) begin
         empty_n = empty_n + WORD_BYTES;
      end
   end

   always_ff @(posedge clk or posedge arst) begin
      if (arst) begin
         avl_valid <= 1'b0;
         avl_sop   <= 1'b0;
         avl_eop   <= 1'b0;
         avl_error <= 1'b0;
         avl_empty <= '0;
      end else begin
         avl_valid <= beat_go;
         avl_sop   <= beat_go & first_ctl.sop;
         avl_eop   <= beat_go & eop_n;
         avl_error <= beat_go & err_n;
         avl_empty <= beat_go ? empty_n : '0;
      end
   end

   // beat data, lower half zeroed on single word beats
   always_ff @(posedge clk) begin
      if (beat_go) begin
         avl_dout <= one_word ?
                     {rd.head_data[2*WORD_WIDTH-1:WORD_WIDTH], {WORD_WIDTH{1'b0}}} :
                     rd.head_data;
      end
   end

endmodule

`default_nettype wire

//--- avl_st_pkg.sv
// outbound avalon-st beat constants
// shared by the output stage and the top level ports
`default_nettype none

package avl_st_pkg;

   // empty byte count of a two word beat, 0..15
   localparam int EMPTY_W = 4;

   // bytes carried by one lane word
   localparam int BYTES_PER_WORD = 8;

endpackage

`default_nettype wire

//--- ilk_word_pkg.sv
// inbound lane word format for the regrouper
// eop code views, stored control entry and the shared end-of-packet test
`default_nettype none

package ilk_word_pkg;

   // words per lane cycle, scheduling is built around two
   localparam int NUM_SLOTS = 2;

   // raw code of an errored packet end
   localparam logic [3:0] ERR_CODE = 4'b0001;

   // one eop code, read raw for the error marker
   // or as end flag plus byte count (count 0 means a full word)
   typedef union packed {
      logic [3:0] raw;
      struct packed {
         logic       endf;
         logic [2:0] cnt;
      } f;
   } eop_code_t;

   // control part of a stored word, data travels beside it
   typedef struct packed {
      logic      sop;
      eop_code_t eop;
   } entry_t;

   // any end flag or the error marker closes a packet
   function automatic logic ends_packet(eop_code_t code);
      return code.f.endf | (code.raw == ERR_CODE);
   endfunction

endpackage

`default_nettype wire

//--- inbound_packer.sv
// lane input stage of the regrouper
// drops words outside a packet and compacts the rest toward the upper slot
`timescale 1ns/1ns
`default_nettype none

module inbound_packer #(
   parameter int WORD_WIDTH = 64
) (
   input  logic                                             clk,
   input  logic                                             arst,
   input  logic [1:0]                                       din_num_valid,
   input  logic [ilk_word_pkg::NUM_SLOTS-1:0]               din_sop,
   input  logic [4*ilk_word_pkg::NUM_SLOTS-1:0]             din_eopbits,
   input  logic [ilk_word_pkg::NUM_SLOTS*WORD_WIDTH-1:0]    din,
   output logic [1:0]                                       wr_count,
   output ilk_word_pkg::entry_t [ilk_word_pkg::NUM_SLOTS-1:0] wr_ctl,
   output logic [ilk_word_pkg::NUM_SLOTS*WORD_WIDTH-1:0]    wr_data
);

   ilk_word_pkg::entry_t [ilk_word_pkg::NUM_SLOTS-1:0] slot_ctl;
   logic in_pkt;
   logic keep_hi, keep_lo;
   logic state_hi, state_lo;

   // split the flat lane flags into per slot entries
   always_comb begin
      for (int i = 0; i < ilk_word_pkg::NUM_SLOTS; i++) begin
         slot_ctl[i].sop     = din_sop[i];
         slot_ctl[i].eop.raw = din_eopbits[4*i +: 4];
      end
   end

   //////////////////////////////////////////////////////////////////////
   // packet tracking, upper slot is first in time
   //////////////////////////////////////////////////////////////////////

   // upper slot valid for any nonzero count
   assign keep_hi  = (|din_num_valid) & (slot_ctl[1].sop | in_pkt);
   assign state_hi = keep_hi ? ~ilk_word_pkg::ends_packet(slot_ctl[1].eop) : in_pkt;

   // lower slot sees the state left by the upper one
   assign keep_lo  = din_num_valid[1] & (slot_ctl[0].sop | state_hi);
   assign state_lo = keep_lo ? ~ilk_word_pkg::ends_packet(slot_ctl[0].eop) : state_hi;

   always_ff @(posedge clk or posedge arst) begin
      if (arst) begin
         in_pkt   <= 1'b0;
         wr_count <= 2'd0;
      end else begin
         in_pkt   <= state_lo;
         wr_count <= 2'(keep_hi) + 2'(keep_lo);
      end
   end

   // compaction, a lone kept lower word moves up
   always_ff @(posedge clk) begin
      if (keep_hi) begin
         wr_ctl[1]                         <= slot_ctl[1];
         wr_data[2*WORD_WIDTH-1:WORD_WIDTH] <= din[2*WORD_WIDTH-1:WORD_WIDTH];
      end else begin
         wr_ctl[1]                         <= slot_ctl[0];
         wr_data[2*WORD_WIDTH-1:WORD_WIDTH] <= din[WORD_WIDTH-1:0];
      end
      // lower slot only counts when both were kept
      wr_ctl[0]                <= slot_ctl[0];
      wr_data[WORD_WIDTH-1:0]  <= din[WORD_WIDTH-1:0];
   end

endmodule

`default_nettype wire

//--- regroup_assertions.sv
// concurrent checks on the read side of the regrouper output stage
// bound into every avl_regroup_out instance
`timescale 1ns/1ns
`default_nettype none

module regroup_assertions (
   input logic        clk,
   input logic        arst,
   input logic [1:0]  take,
   // held widened to a fixed 16 bits
   input logic [15:0] held,
   input logic        avl_valid,
   input logic        avl_sop,
   input logic        avl_eop
);

   int unsigned fail_cnt = 0;
   logic        first_beat;

   // next beat opens a packet after reset or an eop beat
   always_ff @(posedge clk or posedge arst) begin
      if (arst) begin
         first_beat <= 1'b1;
      end else if (avl_valid) begin
         first_beat <= avl_eop;
      end
   end

   take_within_held: assert property (@(posedge clk) disable iff (arst)
      16'(take) <= held)
      else begin
         $error("read take exceeds held word count");
         fail_cnt++;
      end

   flags_need_valid: assert property (@(posedge clk) disable iff (arst)
      (avl_sop || avl_eop) |-> avl_valid)
      else begin
         $error("sop or eop raised without avl_valid");
         fail_cnt++;
      end

   sop_on_first_beat: assert property (@(posedge clk) disable iff (arst)
      avl_valid |-> (avl_sop == first_beat))
      else begin
         $error("avl_sop does not match packet start position");
         fail_cnt++;
      end

endmodule

bind avl_regroup_out regroup_assertions u_chk (
   .clk       (clk),
   .arst      (arst),
   .take      (take_n),
   .held      (16'(rd.held)),
   .avl_valid (avl_valid),
   .avl_sop   (avl_sop),
   .avl_eop   (avl_eop)
);

`default_nettype wire

//--- regroup_top.sv
// regrouper top level, lane words in and two word avalon-st beats out
// set WORD_WIDTH and ADDR_WIDTH here, they pass down to the buffer and stages
`timescale 1ns/1ns
`default_nettype none

module regroup_top #(
   parameter int WORD_WIDTH = 64,
   parameter int ADDR_WIDTH = 6
) (
   input  logic                                          clk,
   input  logic                                          arst,
   // lane side, slot 1 first in time
   input  logic [1:0]                                    din_num_valid,
   input  logic [ilk_word_pkg::NUM_SLOTS-1:0]            din_sop,
   input  logic [4*ilk_word_pkg::NUM_SLOTS-1:0]          din_eopbits,
   input  logic [ilk_word_pkg::NUM_SLOTS*WORD_WIDTH-1:0] din,
   // avalon-st side, first word in the upper half
   output logic [ilk_word_pkg::NUM_SLOTS*WORD_WIDTH-1:0] avl_dout,
   output logic                                          avl_sop,
   output logic                                          avl_eop,
   output logic [avl_st_pkg::EMPTY_W-1:0]                avl_empty,
   output logic                                          avl_valid,
   output logic                                          avl_error,
   output logic                                          overflow
);

   // packer to buffer
   logic [1:0]                                         wr_count;
   ilk_word_pkg::entry_t [ilk_word_pkg::NUM_SLOTS-1:0] wr_ctl;
   logic [ilk_word_pkg::NUM_SLOTS*WORD_WIDTH-1:0]      wr_data;

   // buffer to output stage
   word_rd_if #(.WORD_WIDTH(WORD_WIDTH), .ADDR_WIDTH(ADDR_WIDTH)) rd_bus ();

   inbound_packer #(.WORD_WIDTH(WORD_WIDTH)) u_packer (
      .clk           (clk),
      .arst          (arst),
      .din_num_valid (din_num_valid),
      .din_sop       (din_sop),
      .din_eopbits   (din_eopbits),
      .din           (din),
      .wr_count      (wr_count),
      .wr_ctl        (wr_ctl),
      .wr_data       (wr_data)
   );

   word_buffer #(.WORD_WIDTH(WORD_WIDTH), .ADDR_WIDTH(ADDR_WIDTH)) u_buffer (
      .clk      (clk),
      .arst     (arst),
      .wr_count (wr_count),
      .wr_ctl   (wr_ctl),
      .wr_data  (wr_data),
      .rd       (rd_bus.buffer),
      .overflow (overflow)
   );

   avl_regroup_out #(.WORD_WIDTH(WORD_WIDTH)) u_out (
      .clk       (clk),
      .arst      (arst),
      .rd        (rd_bus.consumer),
      .avl_dout  (avl_dout),
      .avl_sop   (avl_sop),
      .avl_eop   (avl_eop),
      .avl_empty (avl_empty),
      .avl_valid (avl_valid),
      .avl_error (avl_error)
   );

endmodule

`default_nettype wire

//--- tb.f
ilk_word_pkg.sv
avl_st_pkg.sv
word_rd_if.sv
inbound_packer.sv
word_buffer.sv
avl_regroup_out.sv
regroup_top.sv
regroup_assertions.sv
tb_regroup.sv

//--- tb_regroup.sv
// testbench for the regrouper top level
// random packets with garbage between them, reference beats in a queue,
// then a back-to-back single word phase that overruns the buffer
`timescale 1ns/1ns
`default_nettype none

module tb_regroup;

   localparam int WORD_WIDTH    = 64;
   localparam int ADDR_WIDTH    = 6;
   localparam int NUM_PKTS      = 40;
   localparam int DRAIN_TIMEOUT = 300;
   localparam int OVF_TIMEOUT   = 200;

   // one lane word as the producer sends it
   typedef struct packed {
      logic        sop;
      logic [3:0]  eop;
      logic [63:0] data;
   } lane_word_t;

   // one expected output beat
   typedef struct packed {
      logic [127:0] dout;
      logic         sop;
      logic         eop;
      logic         err;
      logic [3:0]   empty;
   } beat_t;

   logic         clk;
   logic         arst;
   logic [1:0]   din_num_valid;
   logic [1:0]   din_sop;
   logic [7:0]   din_eopbits;
   logic [127:0] din;
   logic [127:0] avl_dout;
   logic         avl_sop, avl_eop, avl_valid, avl_error, overflow;
   logic [3:0]   avl_empty;

   lane_word_t  lane_q[$];
   beat_t       exp_q[$];
   logic [63:0] pkt_words[$];
   logic [15:0] lfsr;
   logic        check_on;
   int          cyc;

   regroup_top #(.WORD_WIDTH(WORD_WIDTH), .ADDR_WIDTH(ADDR_WIDTH)) UUT (
      .clk (clk), .arst (arst),
      .din_num_valid (din_num_valid), .din_sop (din_sop),
      .din_eopbits (din_eopbits), .din (din),
      .avl_dout (avl_dout), .avl_sop (avl_sop), .avl_eop (avl_eop),
      .avl_empty (avl_empty), .avl_valid (avl_valid),
      .avl_error (avl_error), .overflow (overflow)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   //////////////////////////////////////////////////////////////////////
   // random source, galois lfsr with taps 16,14,13,11
   //////////////////////////////////////////////////////////////////////

   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
   endfunction

   // one step per bit taken
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] r;
      r = '0;
      for (int i = 0; i < n; i++) begin
         r    = {r[30:0], lfsr[0]};
         lfsr = lfsr_next(lfsr);
      end
      return r;
   endfunction

   //////////////////////////////////////////////////////////////////////
   // reference model and reporting
   //////////////////////////////////////////////////////////////////////

   // pairs from the sop word, odd tail as a single word beat
   function automatic void expect_packet(input int n, input logic [2:0] cnt, input logic err);
      beat_t b;
      int    nb;
      int    end_bytes;
      logic  single;
      nb        = (n + 1) / 2;
      end_bytes = (cnt == 3'd0) ? 8 : int'(cnt);
      for (int k = 0; k < nb; k++) begin
         single = (2 * k + 1 == n);
         if (single) begin
            b.dout = {pkt_words[2*k], 64'h0};
         end else begin
            b.dout = {pkt_words[2*k], pkt_words[2*k+1]};
         end
         b.sop   = (k == 0);
         b.eop   = (k == nb - 1);
         b.err   = b.eop && err;
         b.empty = 4'd0;
         // empty bytes of the last word, plus a whole word if single
         if (b.eop && !err) begin
            b.empty = 4'(8 - end_bytes + (single ? 8 : 0));
         end
         exp_q.push_back(b);
      end
   endfunction

   task automatic report_fail(input string why);
      $display("%s", why);
      $display("TEST RESULT: FAIL");
      $fatal(1, "simulation stopped on first error");
   endtask

   task automatic check_value(input string name, input logic [127:0] exp,
                              input logic [127:0] got);
      if (exp !== got) begin
         report_fail($sformatf("FAIL %s exp %h got %h", name, exp, got));
      end
   endtask

   //////////////////////////////////////////////////////////////////////
   // stimulus
   //////////////////////////////////////////////////////////////////////

   task automatic drive_idle();
      din_num_valid = 2'd0;
      din_sop       = 2'b00;
      din_eopbits   = 8'h00;
      din           = '0;
   endtask

   task automatic apply_reset();
      @(negedge clk);
      arst = 1'b1;
      repeat (3) @(negedge clk);
      arst = 1'b0;
   endtask

   // garbage without sop first, then the packet itself
   task automatic build_packet(input int p);
      lane_word_t w;
      int         n;
      int         g;
      logic [2:0] cnt;
      logic       err;
      g = int'(rand_bits(2)) % 3;
      for (int i = 0; i < g; i++) begin
         w.sop  = 1'b0;
         w.eop  = 4'(rand_bits(4));
         w.data = {rand_bits(32), rand_bits(32)};
         lane_q.push_back(w);
      end
      n   = 1 + int'(rand_bits(4)) % 12;
      cnt = 3'(rand_bits(3));
      err = (rand_bits(3) == 32'd0);
      pkt_words.delete();
      for (int i = 0; i < n; i++) begin
         w.sop  = (i == 0);
         w.eop  = 4'b0000;
         if (i == n - 1) begin
            w.eop = err ? ilk_word_pkg::ERR_CODE : {1'b1, cnt};
         end
         // packet and word index in the upper bits, order shows up in data
         w.data = {16'(p), 16'(i), rand_bits(32)};
         pkt_words.push_back(w.data);
         lane_q.push_back(w);
      end
      expect_packet(n, cnt, err);
   endtask

   // 0..2 words per cycle, unused slots carry a tempting sop word
   task automatic drive_lane();
      lane_word_t w_hi, w_lo;
      lane_word_t junk;
      int         n;
      junk = {1'b1, 4'b1000, 64'hffff_0000_ffff_0000};
      while (lane_q.size() > 0) begin
         @(negedge clk);
         n = int'(rand_bits(2)) % 3;
         if (n > lane_q.size()) begin
            n = lane_q.size();
         end
         w_hi = junk;
         w_lo = junk;
         if (n >= 1) begin
            w_hi = lane_q.pop_front();
         end
         if (n == 2) begin
            w_lo = lane_q.pop_front();
         end
         din_num_valid = 2'(n);
         din_sop       = {w_hi.sop, w_lo.sop};
         din_eopbits   = {w_hi.eop, w_lo.eop};
         din           = {w_hi.data, w_lo.data};
      end
      @(negedge clk);
      drive_idle();
   endtask

   //////////////////////////////////////////////////////////////////////
   // comparing process, outputs settle after the rising edge
   //////////////////////////////////////////////////////////////////////

   initial begin
      beat_t e;
      forever begin
         @(negedge clk);
         if (UUT.u_out.u_chk.fail_cnt != 0) begin
            report_fail("a bound assertion on the buffer read side failed");
         end
         if (avl_valid === 1'b1 && check_on) begin
            if (exp_q.size() == 0) begin
               report_fail("avl_valid beat seen with no expected beat pending");
            end
            e = exp_q.pop_front();
            check_value("avl_dout", e.dout, avl_dout);
            check_value("avl_sop", 128'(e.sop), 128'(avl_sop));
            check_value("avl_eop", 128'(e.eop), 128'(avl_eop));
            check_value("avl_error", 128'(e.err), 128'(avl_error));
            check_value("avl_empty", 128'(e.empty), 128'(avl_empty));
         end
      end
   end

   //////////////////////////////////////////////////////////////////////
   // main sequence
   //////////////////////////////////////////////////////////////////////

   initial begin
      lfsr     = 16'd96;
      check_on = 1'b1;
      arst     = 1'b1;
      drive_idle();
      repeat (3) @(negedge clk);
      arst = 1'b0;

      // idle after reset
      repeat (8) begin
         @(negedge clk);
         check_value("avl_valid", 128'(0), 128'(avl_valid));
         check_value("overflow", 128'(0), 128'(overflow));
      end

      for (int p = 0; p < NUM_PKTS; p++) begin
         build_packet(p);
      end
      drive_lane();

      cyc = 0;
      while (exp_q.size() != 0) begin
         if (cyc >= DRAIN_TIMEOUT) begin
            report_fail("timeout, expected beats still pending after the last packet");
         end
         @(negedge clk);
         cyc++;
      end
      // stray beats would show up here
      repeat (10) @(negedge clk);
      check_value("overflow", 128'(0), 128'(overflow));

      // overrun with back-to-back single word packets
      check_on = 1'b0;
      apply_reset();
      check_value("overflow", 128'(0), 128'(overflow));
      cyc = 0;
      while (overflow !== 1'b1) begin
         if (cyc >= OVF_TIMEOUT) begin
            report_fail("timeout, overflow never rose under a full rate input");
         end
         @(negedge clk);
         din_num_valid = 2'd2;
         din_sop       = 2'b11;
         din_eopbits   = 8'h88;
         din           = {rand_bits(32), rand_bits(32), rand_bits(32), rand_bits(32)};
         cyc++;
      end
      drive_idle();
      // sticky until reset
      repeat (20) begin
         @(negedge clk);
         check_value("overflow", 128'(1), 128'(overflow));
      end
      apply_reset();
      check_value("overflow", 128'(0), 128'(overflow));
      check_value("avl_valid", 128'(0), 128'(avl_valid));
      check_on = 1'b1;
      repeat (10) @(negedge clk);

      // late assertion failures still end the run as a failure
      if (UUT.u_out.u_chk.fail_cnt != 0) begin
         report_fail("a bound assertion failed near the end of the run");
      end else begin
         $display("TEST RESULT: PASS");
         $finish;
      end
   end

endmodule

`default_nettype wire

//--- word_buffer.sv
// circular word store between the packer and the output stage
// 0..2 word writes and reads per cycle, sticky overflow on overrun
`timescale 1ns/1ns
`default_nettype none

module word_buffer #(
   parameter int WORD_WIDTH = 64,
   parameter int ADDR_WIDTH = 6
) (
   input  logic                                               clk,
   input  logic                                               arst,
   input  logic [1:0]                                         wr_count,
   input  ilk_word_pkg::entry_t [ilk_word_pkg::NUM_SLOTS-1:0] wr_ctl,
   input  logic [ilk_word_pkg::NUM_SLOTS*WORD_WIDTH-1:0]      wr_data,
   word_rd_if.buffer                                          rd,
   output logic                                               overflow
);

   localparam int DEPTH = 1 << ADDR_WIDTH;

   ilk_word_pkg::entry_t  ctl_mem  [DEPTH];
   logic [WORD_WIDTH-1:0] data_mem [DEPTH];

   // one extra pointer bit so a full buffer reads as DEPTH
   logic [ADDR_WIDTH:0]   wr_ptr, rd_ptr, held_cnt;
   logic [ADDR_WIDTH+1:0] fill_next;
   logic [ADDR_WIDTH-1:0] wr_a0, wr_a1, rd_a0, rd_a1;
   logic                  wr_fits;

   assign held_cnt  = wr_ptr - rd_ptr;
   assign fill_next = (ADDR_WIDTH+2)'(held_cnt) + (ADDR_WIDTH+2)'(wr_count);
   assign wr_fits   = fill_next <= (ADDR_WIDTH+2)'(DEPTH);

   // word addresses wrap on their own
   assign wr_a0 = wr_ptr[ADDR_WIDTH-1:0];
   assign wr_a1 = wr_a0 + 1'b1;
   assign rd_a0 = rd_ptr[ADDR_WIDTH-1:0];
   assign rd_a1 = rd_a0 + 1'b1;

   //////////////////////////////////////////////////////////////////////
   // storage
   //////////////////////////////////////////////////////////////////////

   // an overrunning write is dropped whole
   always_ff @(posedge clk) begin
      if (wr_fits && wr_count != 2'd0) begin
         ctl_mem[wr_a0]  <= wr_ctl[1];
         data_mem[wr_a0] <= wr_data[2*WORD_WIDTH-1:WORD_WIDTH];
      end
      if (wr_fits && wr_count == 2'd2) begin
         ctl_mem[wr_a1]  <= wr_ctl[0];
         data_mem[wr_a1] <= wr_data[WORD_WIDTH-1:0];
      end
   end

   // pointers and sticky overrun
   always_ff @(posedge clk or posedge arst) begin
      if (arst) begin
         wr_ptr   <= '0;
         rd_ptr   <= '0;
         overflow <= 1'b0;
      end else begin
         if (wr_fits) begin
            wr_ptr <= wr_ptr + (ADDR_WIDTH+1)'(wr_count);
         end else begin
            overflow <= 1'b1;
         end
         rd_ptr <= rd_ptr + (ADDR_WIDTH+1)'(rd.take);
      end
   end

   // head words, first in the upper slot
   assign rd.held        = held_cnt;
   assign rd.head_ctl[1] = ctl_mem[rd_a0];
   assign rd.head_ctl[0] = ctl_mem[rd_a1];
   assign rd.head_data   = {data_mem[rd_a0], data_mem[rd_a1]};

endmodule

`default_nettype wire

//--- word_rd_if.sv
// read side of the word buffer
// buffer presents its two head words and fill level, consumer returns a take count
`timescale 1ns/1ns
`default_nettype none

interface word_rd_if #(
   parameter int WORD_WIDTH = 64,
   parameter int ADDR_WIDTH = 6
);
   // words currently stored, reaches full depth
   logic [ADDR_WIDTH:0] held;
   // first word in the upper slot
   ilk_word_pkg::entry_t [ilk_word_pkg::NUM_SLOTS-1:0] head_ctl;
   logic [ilk_word_pkg::NUM_SLOTS*WORD_WIDTH-1:0]      head_data;
   // words consumed this cycle, never above held
   logic [1:0] take;

   modport buffer   (output held, head_ctl, head_data, input take);
   modport consumer (input held, head_ctl, head_data, output take);
endinterface

`default_nettype wire
